//--- Makefile
# Verilator build for the pcie_app_top loopback testbench

TOP := tb_pcie_app

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" sim.log; then echo "no verdict in sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- app_reset_ctrl.sv
`timescale 1ns/100ps
`include "pcie_app_macros.svh"

module app_reset_ctrl (
   input  logic                        pld_clk,
   input  logic                        reset_status_sync_pldclk,
   input  hip_status_pkg::hip_status_t status_q,
   input  hip_status_pkg::cfg_regs_t   cfg_regs,
   output logic                        app_active
);

   hip_status_pkg::link_state_e state_q;
   hip_status_pkg::link_state_e state_d;
   logic                        link_exit;
   logic                        link_ready;
   logic                        bus_master_en;

   // exit strobes from the core are active low
   assign link_exit = ~status_q.dlup_exit | ~status_q.hotrst_exit |
                      ~status_q.l2_exit | ~status_q.dlup;

   assign link_ready    = (status_q.ltssmstate == `LTSSM_L0) & status_q.dlup;
   assign bus_master_en = cfg_regs.cfg_prmcsr[`BME_BIT];

   always_comb begin
      state_d = state_q;
      if (link_exit) begin
         state_d = hip_status_pkg::LINK_DOWN;
      end else begin
         case (state_q)
            hip_status_pkg::LINK_DOWN: begin
               if (link_ready) begin
                  state_d = hip_status_pkg::LINK_UP;
               end
            end
            hip_status_pkg::LINK_UP: begin
               if (bus_master_en) begin
                  state_d = hip_status_pkg::APP_ACTIVE;
               end
            end
            hip_status_pkg::APP_ACTIVE: begin
               // host revoked mastering, link itself is still fine
               if (!bus_master_en) begin
                  state_d = hip_status_pkg::LINK_UP;
               end
            end
            default: begin
               state_d = hip_status_pkg::LINK_DOWN;
            end
         endcase
      end
   end

   always_ff @(posedge pld_clk or posedge reset_status_sync_pldclk) begin
      if (reset_status_sync_pldclk) begin
         state_q    <= hip_status_pkg::LINK_DOWN;
         app_active <= 1'b0;
      end else begin
         state_q    <= state_d;
         app_active <= (state_d == hip_status_pkg::APP_ACTIVE);
      end
   end

   // a link drop must close the enable before it can reopen
   a_no_active_after_dlup_loss: assert property (
      @(posedge pld_clk) disable iff (reset_status_sync_pldclk)
      app_active |-> $past(status_q.dlup, 2)
   );

endmodule

//--- ast_loopback.sv
`timescale 1ns/100ps

module ast_loopback (
   input  logic                      pld_clk,
   input  logic                      reset_status_sync_pldclk,
   input  logic                      app_active,
   input  ast_stream_pkg::ast_beat_t rx_beat,
   input  logic                      rx_st_valid,
   output logic                      rx_st_ready,
   output logic                      rx_st_mask,
   output ast_stream_pkg::ast_beat_t tx_beat,
   output logic                      tx_st_valid,
   input  logic                      tx_st_ready
);

   ast_stream_pkg::stage_e    s0_q;
   ast_stream_pkg::stage_e    s1_q;
   ast_stream_pkg::ast_beat_t s0_beat;
   ast_stream_pkg::ast_beat_t s1_beat;
   logic                      tx_pop;
   logic                      s1_load;
   logic                      s0_load;

   // output stage drains on a tx handshake
   assign tx_pop = (s1_q == ast_stream_pkg::STAGE_FULL) & tx_st_ready;

   // stage 0 moves forward when stage 1 is free or being emptied
   assign s1_load = (s0_q == ast_stream_pkg::STAGE_FULL) &
                    ((s1_q == ast_stream_pkg::STAGE_EMPTY) | tx_pop);

   // accept only while enabled and stage 0 has room this cycle
   assign rx_st_ready = app_active & ((s0_q == ast_stream_pkg::STAGE_EMPTY) | s1_load);
   assign s0_load     = rx_st_valid & rx_st_ready;
   assign rx_st_mask  = ~app_active;

   always_ff @(posedge pld_clk or posedge reset_status_sync_pldclk) begin
      if (reset_status_sync_pldclk) begin
         s0_q <= ast_stream_pkg::STAGE_EMPTY;
         s1_q <= ast_stream_pkg::STAGE_EMPTY;
      end else begin
         if (s0_load) begin
            s0_q <= ast_stream_pkg::STAGE_FULL;
         end else if (s1_load) begin
            s0_q <= ast_stream_pkg::STAGE_EMPTY;
         end
         if (s1_load) begin
            s1_q <= ast_stream_pkg::STAGE_FULL;
         end else if (tx_pop) begin
            s1_q <= ast_stream_pkg::STAGE_EMPTY;
         end
      end
   end

   // payload follows the occupancy flags
   always_ff @(posedge pld_clk) begin
      if (s0_load) begin
         s0_beat <= rx_beat;
      end
      if (s1_load) begin
         s1_beat <= s0_beat;
      end
   end

   assign tx_beat     = s1_beat;
   assign tx_st_valid = (s1_q == ast_stream_pkg::STAGE_FULL);

   // a stalled beat holds until the sink takes it
   a_tx_stable: assert property (
      @(posedge pld_clk) disable iff (reset_status_sync_pldclk)
      (tx_st_valid && !tx_st_ready) |=> (tx_st_valid && $stable(tx_beat))
   );

   a_rx_gated: assert property (
      @(posedge pld_clk) disable iff (reset_status_sync_pldclk)
      !app_active |-> !rx_st_ready
   );

endmodule

//--- ast_stream_pkg.sv
`include "pcie_app_macros.svh"

package ast_stream_pkg;

   // one 64-bit avalon-st beat with its sideband
   typedef struct packed {
      logic [`PCIE_DATA_W-1:0] data;
      logic [`PCIE_BE_W-1:0]   be;
      logic                    sop;
      logic                    eop;
      logic                    err;
      // any rx_st_bar bit set
      logic                    bar_hit;
   } ast_beat_t;

   // occupancy of one pipeline register
   typedef enum logic {
      STAGE_EMPTY = 1'b0,
      STAGE_FULL  = 1'b1
   } stage_e;

endpackage

//--- hip_status_pkg.sv
`include "pcie_app_macros.svh"

package hip_status_pkg;

   // status bundle from the hard ip, msb first
   typedef struct packed {
      logic                  derr_cor_ext_rcv;
      logic                  derr_cor_ext_rpl;
      logic                  derr_rpl;
      logic                  rx_par_err;
      logic [1:0]            tx_par_err;
      logic                  cfg_par_err;
      logic                  dlup;
      // active-low exit pulses
      logic                  dlup_exit;
      logic                  ev128ns;
      logic                  ev1us;
      logic                  hotrst_exit;
      logic [3:0]            int_status;
      logic                  l2_exit;
      logic [3:0]            lane_act;
      logic [`LTSSM_W-1:0]   ltssmstate;
      logic [7:0]            ko_cpl_spc_header;
      logic [11:0]           ko_cpl_spc_data;
   } hip_status_t;

   // configuration registers decoded from tl_cfg_ctl
   typedef struct packed {
      logic [`CFG_CTL_W-1:0] cfg_devcsr;
      logic [`CFG_CTL_W-1:0] cfg_linkcsr;
      logic [`CFG_CTL_W-1:0] cfg_prmcsr;
      logic [12:0]           cfg_busdev;
   } cfg_regs_t;

   // application enable FSM
   typedef enum logic [1:0] {
      LINK_DOWN  = 2'd0,
      LINK_UP    = 2'd1,
      APP_ACTIVE = 2'd2
   } link_state_e;

endpackage

//--- hip_status_sampler.sv
`timescale 1ns/100ps

module hip_status_sampler (
   input  logic                      pld_clk,
   input  logic                      reset_status_sync_pldclk,
   input  hip_status_pkg::hip_status_t status_in,
   output hip_status_pkg::hip_status_t status_q
);

   // single register stage on the whole bundle
   // the result is both the echo and the link-control input
   always_ff @(posedge pld_clk or posedge reset_status_sync_pldclk) begin
      if (reset_status_sync_pldclk) begin
         status_q <= '0;
      end else begin
         status_q <= status_in;
      end
   end

endmodule

//--- pcie_app_macros.svh
`ifndef PCIE_APP_MACROS_SVH
`define PCIE_APP_MACROS_SVH

// avalon-st stream widths, 64-bit mode only
`define PCIE_DATA_W      64
`define PCIE_BE_W        8

// ltssm encoding from the hard ip
`define LTSSM_W          5
`define LTSSM_L0         5'h0F

// transaction-layer configuration bus
`define CFG_ADDR_W       4
`define CFG_CTL_W        32
`define CFG_A_DEVCSR     4'd0
`define CFG_A_LINKCSR    4'd2
`define CFG_A_PRMCSR     4'd3
`define CFG_A_BUSDEV     4'd15

// bus master enable inside prmcsr
`define BME_BIT          2

// depth of the pld_clk reset synchronizer
`define RST_SYNC_STAGES  3

`endif

//--- pcie_app_top.sv
`timescale 1ns/100ps
`include "pcie_app_macros.svh"

module pcie_app_top (
   input  logic                        pld_clk,
   input  logic                        reset_status,
   input  logic                        serdes_pll_locked,
   output logic                        pld_core_ready,
   input  hip_status_pkg::hip_status_t status_in,
   output hip_status_pkg::hip_status_t status_drv,
   input  logic [`CFG_ADDR_W-1:0]      tl_cfg_add,
   input  logic [`CFG_CTL_W-1:0]       tl_cfg_ctl,
   output hip_status_pkg::cfg_regs_t   cfg_regs,
   output logic                        app_active,
   input  ast_stream_pkg::ast_beat_t   rx_beat,
   input  logic                        rx_st_valid,
   output logic                        rx_st_ready,
   output logic                        rx_st_mask,
   output ast_stream_pkg::ast_beat_t   tx_beat,
   output logic                        tx_st_valid,
   input  logic                        tx_st_ready
);

   logic reset_status_sync_pldclk;

   // core is ready as soon as the serdes pll is
   assign pld_core_ready = serdes_pll_locked;

   pld_reset_sync u_reset_sync (
      .pld_clk                  (pld_clk),
      .reset_status             (reset_status),
      .reset_status_sync_pldclk (reset_status_sync_pldclk)
   );

   // registered status doubles as the echo
   hip_status_sampler u_status_sampler (
      .pld_clk                  (pld_clk),
      .reset_status_sync_pldclk (reset_status_sync_pldclk),
      .status_in                (status_in),
      .status_q                 (status_drv)
   );

   tl_cfg_sampler u_cfg_sampler (
      .pld_clk                  (pld_clk),
      .reset_status_sync_pldclk (reset_status_sync_pldclk),
      .tl_cfg_add               (tl_cfg_add),
      .tl_cfg_ctl               (tl_cfg_ctl),
      .cfg_regs                 (cfg_regs)
   );

   app_reset_ctrl u_app_ctrl (
      .pld_clk                  (pld_clk),
      .reset_status_sync_pldclk (reset_status_sync_pldclk),
      .status_q                 (status_drv),
      .cfg_regs                 (cfg_regs),
      .app_active               (app_active)
   );

   ast_loopback u_loopback (
      .pld_clk                  (pld_clk),
      .reset_status_sync_pldclk (reset_status_sync_pldclk),
      .app_active               (app_active),
      .rx_beat                  (rx_beat),
      .rx_st_valid              (rx_st_valid),
      .rx_st_ready              (rx_st_ready),
      .rx_st_mask               (rx_st_mask),
      .tx_beat                  (tx_beat),
      .tx_st_valid              (tx_st_valid),
      .tx_st_ready              (tx_st_ready)
   );

endmodule

//--- pld_reset_sync.sv
`timescale 1ns/100ps
`include "pcie_app_macros.svh"

module pld_reset_sync (
   input  logic pld_clk,
   input  logic reset_status,
   output logic reset_status_sync_pldclk
);

   logic [`RST_SYNC_STAGES-1:0] sync_q;

   // assert at once, release after the chain has flushed with zeros
   always_ff @(posedge pld_clk or posedge reset_status) begin
      if (reset_status) begin
         sync_q <= '1;
      end else begin
         sync_q <= {sync_q[`RST_SYNC_STAGES-2:0], 1'b0};
      end
   end

   assign reset_status_sync_pldclk = sync_q[`RST_SYNC_STAGES-1];

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
   output logic pld_clk,
   output logic reset_status
);

   // 10 ns period
   initial begin
      pld_clk = 1'b0;
      forever begin
         #5 pld_clk = ~pld_clk;
      end
   end

   // reset held for 10 cycles and released on a falling edge
   initial begin
      reset_status = 1'b1;
      repeat (10) @(posedge pld_clk);
      @(negedge pld_clk);
      reset_status = 1'b0;
   end

endmodule

//--- tb_pcie_app.sv
`timescale 1ns/100ps
`include "pcie_app_macros.svh"

module tb_pcie_app;

   localparam int NS = 4;
   localparam int NC = 8;
   localparam int NB = 8;
   localparam int WAIT_LIMIT = 50;
   localparam int LOOP_LIMIT = 400;

   // one configuration bus write
   typedef struct packed {
      logic [`CFG_ADDR_W-1:0] add;
      logic [`CFG_CTL_W-1:0]  ctl;
   } cfg_write_t;

   logic                          pld_clk;
   logic                          reset_status;
   logic                          serdes_pll_locked;
   logic                          pld_core_ready;
   hip_status_pkg::hip_status_t   status_in;
   hip_status_pkg::hip_status_t   status_drv;
   hip_status_pkg::hip_status_t   link_stat;
   logic [`CFG_ADDR_W-1:0]        tl_cfg_add;
   logic [`CFG_CTL_W-1:0]         tl_cfg_ctl;
   hip_status_pkg::cfg_regs_t     cfg_regs;
   hip_status_pkg::cfg_regs_t     cfg_model;
   logic                          app_active;
   ast_stream_pkg::ast_beat_t     rx_beat;
   logic                          rx_st_valid;
   logic                          rx_st_ready;
   logic                          rx_st_mask;
   ast_stream_pkg::ast_beat_t     tx_beat;
   logic                          tx_st_valid;
   logic                          tx_st_ready;

   hip_status_pkg::hip_status_t   status_tab [NS];
   cfg_write_t                    cfg_tab [NC];
   ast_stream_pkg::ast_beat_t     beat_tab [NB];

   integer seed;
   integer rnd;
   int     errors;
   int     rx_idx;
   int     out_idx;
   int     cycles;

   tb_clock_gen u_clk (
      .pld_clk      (pld_clk),
      .reset_status (reset_status)
   );

   pcie_app_top u_dut (
      .pld_clk           (pld_clk),
      .reset_status      (reset_status),
      .serdes_pll_locked (serdes_pll_locked),
      .pld_core_ready    (pld_core_ready),
      .status_in         (status_in),
      .status_drv        (status_drv),
      .tl_cfg_add        (tl_cfg_add),
      .tl_cfg_ctl        (tl_cfg_ctl),
      .cfg_regs          (cfg_regs),
      .app_active        (app_active),
      .rx_beat           (rx_beat),
      .rx_st_valid       (rx_st_valid),
      .rx_st_ready       (rx_st_ready),
      .rx_st_mask        (rx_st_mask),
      .tx_beat           (tx_beat),
      .tx_st_valid       (tx_st_valid),
      .tx_st_ready       (tx_st_ready)
   );

   // write one config word and check the decoded registers two cycles later
   task automatic write_cfg(input logic [`CFG_ADDR_W-1:0] addr, input logic [31:0] data);
      @(negedge pld_clk);
      tl_cfg_add = addr;
      tl_cfg_ctl = data;
      @(negedge pld_clk);
      @(negedge pld_clk);
      case (addr)
         4'd0: cfg_model.cfg_devcsr = data;
         4'd2: cfg_model.cfg_linkcsr = data;
         4'd3: cfg_model.cfg_prmcsr = data;
         4'd15: cfg_model.cfg_busdev = data[12:0];
         default: cfg_model = cfg_model;
      endcase
      if (cfg_regs !== cfg_model) begin
         $display("error: cfg_regs got %h exp %h", cfg_regs, cfg_model);
         errors++;
      end
   endtask

   // poll app_active on falling edges until it reaches the wanted level
   task automatic wait_app_active(input logic level);
      int n;
      n = 0;
      while ((app_active !== level) && (n < WAIT_LIMIT)) begin
         @(negedge pld_clk);
         n++;
      end
      if (app_active !== level) begin
         $display("timed out waiting for app_active to become %0d", level);
         errors++;
      end
   endtask

   initial begin
      seed = 32'he20d462f;
      errors = 0;
      serdes_pll_locked = 1'b0;
      // busy values on the status and config buses while reset is held
      status_in = '1;
      tl_cfg_add = 4'd3;
      tl_cfg_ctl = '1;
      rx_beat = '0;
      rx_st_valid = 1'b0;
      tx_st_ready = 1'b0;
      cfg_model = '0;

      status_tab[0] = 46'h2a5c_1e3b_7d91;
      status_tab[1] = 46'h15a3_e1c4_826e;
      status_tab[2] = 46'h3fff_ffff_ffff;
      status_tab[3] = 46'h0123_4567_89ab;

      cfg_tab[0] = {4'd0, 32'h1234_5678};
      cfg_tab[1] = {4'd2, 32'h0011_0041};
      cfg_tab[2] = {4'd1, 32'hdead_beef};
      cfg_tab[3] = {4'd15, 32'hffff_a5a5};
      cfg_tab[4] = {4'd7, 32'hcafe_f00d};
      cfg_tab[5] = {4'd3, 32'h0000_0003};
      cfg_tab[6] = {4'd0, 32'h8765_4321};
      cfg_tab[7] = {4'd3, 32'h0000_0000};

      for (int i = 0; i < NB; i++) begin
         beat_tab[i].data    = {32'h1000_0000 + i, 32'hc0de_0000 ^ (i * 32'h1111)};
         beat_tab[i].be      = 8'hff >> (i % 4);
         beat_tab[i].sop     = (i % 3 == 0);
         beat_tab[i].eop     = (i % 3 == 2);
         beat_tab[i].err     = (i == 5);
         beat_tab[i].bar_hit = i[0];
      end

      // reset values through the release of the raw reset
      // pld_core_ready is a straight feed-through
      for (int i = 0; i < 12; i++) begin
         @(negedge pld_clk);
         serdes_pll_locked = i[0];
         #2;
         if (pld_core_ready !== serdes_pll_locked) begin
            $display("error: pld_core_ready got %h exp %h", pld_core_ready, serdes_pll_locked);
            errors++;
         end
         if ((app_active !== 1'b0) || (tx_st_valid !== 1'b0) || (rx_st_ready !== 1'b0)) begin
            $display("error: app_active/tx_st_valid/rx_st_ready got %h exp 0",
                     {app_active, tx_st_valid, rx_st_ready});
            errors++;
         end
         if ((status_drv !== '0) || (cfg_regs !== '0)) begin
            $display("error: status_drv got %h cfg_regs got %h exp 0", status_drv, cfg_regs);
            errors++;
         end
      end
      // idle buses before the synchronized reset lets go
      @(negedge pld_clk);
      serdes_pll_locked = 1'b1;
      status_in = '0;
      tl_cfg_add = 4'd5;
      tl_cfg_ctl = '0;

      // status echo one cycle behind
      for (int i = 0; i < NS; i++) begin
         @(negedge pld_clk);
         status_in = status_tab[i];
         @(negedge pld_clk);
         if (status_drv !== status_tab[i]) begin
            $display("error: status_drv got %h exp %h", status_drv, status_tab[i]);
            errors++;
         end
      end

      // link trained with the exit strobes idle high
      link_stat = '0;
      link_stat.dlup        = 1'b1;
      link_stat.dlup_exit   = 1'b1;
      link_stat.hotrst_exit = 1'b1;
      link_stat.l2_exit     = 1'b1;
      link_stat.ltssmstate  = `LTSSM_L0;
      link_stat.lane_act    = 4'h4;
      @(negedge pld_clk);
      status_in = link_stat;

      for (int i = 0; i < NC; i++) begin
         write_cfg(cfg_tab[i].add, cfg_tab[i].ctl);
      end

      // enable, revoke bus master, re-enable, then a dlup_exit pulse
      write_cfg(4'd3, 32'h0000_0004);
      wait_app_active(1'b1);
      write_cfg(4'd3, 32'h0000_0000);
      wait_app_active(1'b0);
      write_cfg(4'd3, 32'h0000_0006);
      wait_app_active(1'b1);
      @(negedge pld_clk);
      status_in.dlup_exit = 1'b0;
      @(negedge pld_clk);
      status_in.dlup_exit = 1'b1;
      wait_app_active(1'b0);
      wait_app_active(1'b1);

      // loopback with random sink stalls
      rx_idx = 0;
      out_idx = 0;
      cycles = 0;
      while ((out_idx < NB) && (cycles < LOOP_LIMIT)) begin
         @(negedge pld_clk);
         rnd = $random(seed);
         tx_st_ready = rnd[0] | rnd[1];
         rx_st_valid = (rx_idx < NB);
         if (rx_idx < NB) begin
            rx_beat = beat_tab[rx_idx];
         end
         #2;
         if (rx_st_mask !== 1'b0) begin
            $display("error: rx_st_mask got %h exp 0", rx_st_mask);
            errors++;
         end
         if (rx_st_valid && rx_st_ready) begin
            rx_idx++;
         end
         if (tx_st_valid && tx_st_ready) begin
            if (tx_beat !== beat_tab[out_idx]) begin
               $display("error: tx_beat got %h exp %h", tx_beat, beat_tab[out_idx]);
               errors++;
            end
            out_idx++;
         end
         cycles++;
      end
      if (out_idx < NB) begin
         $display("timed out in loopback with %0d of %0d beats returned", out_idx, NB);
         errors++;
      end
      @(negedge pld_clk);
      rx_st_valid = 1'b0;

      // gating with the receive side closed and nothing left to send
      write_cfg(4'd3, 32'h0000_0000);
      wait_app_active(1'b0);
      for (int i = 0; i < 20; i++) begin
         @(negedge pld_clk);
         rx_st_valid = 1'b1;
         rx_beat = beat_tab[i % NB];
         tx_st_ready = 1'b1;
         #2;
         if ((rx_st_ready !== 1'b0) || (rx_st_mask !== 1'b1)) begin
            $display("error: rx_st_ready/rx_st_mask got %h exp 1", {rx_st_ready, rx_st_mask});
            errors++;
         end
         if (tx_st_valid !== 1'b0) begin
            $display("error: tx_st_valid got %h exp 0", tx_st_valid);
            errors++;
         end
      end

      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- tl_cfg_sampler.sv
`timescale 1ns/100ps
`include "pcie_app_macros.svh"

module tl_cfg_sampler (
   input  logic                      pld_clk,
   input  logic                      reset_status_sync_pldclk,
   input  logic [`CFG_ADDR_W-1:0]    tl_cfg_add,
   input  logic [`CFG_CTL_W-1:0]     tl_cfg_ctl,
   output hip_status_pkg::cfg_regs_t cfg_regs
);

   logic [`CFG_ADDR_W-1:0] cfg_add_q;
   logic [`CFG_CTL_W-1:0]  cfg_ctl_q;

   // first stage, capture the bus as it comes from the core
   always_ff @(posedge pld_clk or posedge reset_status_sync_pldclk) begin
      if (reset_status_sync_pldclk) begin
         cfg_add_q <= '0;
         cfg_ctl_q <= '0;
      end else begin
         cfg_add_q <= tl_cfg_add;
         cfg_ctl_q <= tl_cfg_ctl;
      end
   end

   // second stage, update only the addressed field
   always_ff @(posedge pld_clk or posedge reset_status_sync_pldclk) begin
      if (reset_status_sync_pldclk) begin
         cfg_regs <= '0;
      end else begin
         case (cfg_add_q)
            `CFG_A_DEVCSR: begin
               cfg_regs.cfg_devcsr <= cfg_ctl_q;
            end
            `CFG_A_LINKCSR: begin
               cfg_regs.cfg_linkcsr <= cfg_ctl_q;
            end
            `CFG_A_PRMCSR: begin
               cfg_regs.cfg_prmcsr <= cfg_ctl_q;
            end
            `CFG_A_BUSDEV: begin
               // bus, device and function numbers sit in the low bits
               cfg_regs.cfg_busdev <= cfg_ctl_q[12:0];
            end
            default: begin
               cfg_regs <= cfg_regs;
            end
         endcase
      end
   end

endmodule

//--- vlog.f
+incdir+.
hip_status_pkg.sv
ast_stream_pkg.sv
pld_reset_sync.sv
hip_status_sampler.sv
tl_cfg_sampler.sv
app_reset_ctrl.sv
ast_loopback.sv
pcie_app_top.sv
tb_clock_gen.sv
tb_pcie_app.sv
